//--- files.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/free_list_if.sv
hdl/free_list.sv
hdl/rename_map.sv
hdl/retire_map.sv
hdl/rename_top.sv
testbench/rename_tb.sv

//--- hdl/free_list.sv
/* circular queue of free physical registers with speculative and committed heads
   instantiated once in the rename top level behind the list_mp modport */

`timescale 1ns/1ps
`include "rename_params.svh"

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    free_list_if.list_mp          fl,
    input  logic                  flush_i,
    output rename_pkg::free_cnt_t free_count_o
);
    import rename_pkg::*;

    // ============================================================
    // state
    // ============================================================

    // queue payload
    phys_reg_t free_q [`RN_FREE_DEPTH];

    // depth is a power of two, so pointers just wrap
    free_ptr_t spec_head_q;
    free_ptr_t commit_head_q;
    free_ptr_t tail_q;

    // free entries after the speculative head
    free_cnt_t count_q;
    free_cnt_t count_d;
    // entries from the committed head to the tail
    free_cnt_t commit_count_q;
    free_cnt_t commit_count_d;

    logic empty;
    logic grant;

    // ============================================================
    // grant and bypass
    // ============================================================

    assign empty = (count_q == '0);

    // a release in this cycle counts as an entry
    assign fl.alloc_ok = !empty || fl.rel_valid;
    assign grant       = fl.alloc_req && fl.alloc_ok;

    // empty queue hands out the released register directly
    assign fl.alloc_phys = empty ? fl.rel_phys : free_q[spec_head_q];

    assign free_count_o = count_q;

    // committed occupancy grows on release and shrinks on commit
    always_comb begin
        commit_count_d = commit_count_q;
        if (fl.rel_valid && !fl.commit_adv) begin
            commit_count_d = commit_count_q + 1'b1;
        end else if (fl.commit_adv && !fl.rel_valid) begin
            commit_count_d = commit_count_q - 1'b1;
        end
    end

    // flush drops speculative occupancy back to the committed view
    always_comb begin
        count_d = count_q;
        if (flush_i) begin
            count_d = commit_count_d;
        end else if (fl.rel_valid && !grant) begin
            count_d = count_q + 1'b1;
        end else if (grant && !fl.rel_valid) begin
            count_d = count_q - 1'b1;
        end
    end

    // ============================================================
    // pointers and counts
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            spec_head_q    <= '0;
            commit_head_q  <= '0;
            // tail sits at depth modulo depth
            tail_q         <= '0;
            count_q        <= free_cnt_t'(`RN_FREE_DEPTH);
            commit_count_q <= free_cnt_t'(`RN_FREE_DEPTH);
        end else begin
            count_q        <= count_d;
            commit_count_q <= commit_count_d;
            if (fl.rel_valid) begin
                tail_q <= tail_q + 1'b1;
            end
            if (fl.commit_adv) begin
                commit_head_q <= commit_head_q + 1'b1;
            end
            // flush rewinds the speculative head to the committed head
            if (flush_i) begin
                spec_head_q <= commit_head_q;
            end else if (grant) begin
                spec_head_q <= spec_head_q + 1'b1;
            end
        end
    end

    // queue starts out holding every register above the architectural ones
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                free_q[i] <= phys_reg_t'(i + `RN_ARCH_REGS);
            end
        end else if (fl.rel_valid) begin
            free_q[tail_q] <= fl.rel_phys;
        end
    end

    // ============================================================
    // checks
    // ============================================================

    count_bound: assert property (@(posedge clock) disable iff (reset)
        count_q <= free_cnt_t'(`RN_FREE_DEPTH));

    // a dry queue has its speculative head on the tail so only the bypass can grant
    no_grant_when_dry: assert property (@(posedge clock) disable iff (reset)
        empty |-> (spec_head_q == tail_q));

endmodule

//--- hdl/free_list_if.sv
/* allocation, release and commit traffic between the two map tables and the free list
   one instance in the top level, each block connects through its own modport */

`timescale 1ns/1ps

interface free_list_if;
    import rename_pkg::*;

    // allocation side, combinational request and grant
    logic      alloc_req;
    logic      alloc_ok;
    phys_reg_t alloc_phys;

    // release side, superseded register from retirement
    logic      rel_valid;
    phys_reg_t rel_phys;

    // one pulse per committed instruction
    logic      commit_adv;

    // speculative map takes registers
    modport alloc_mp (output alloc_req, input alloc_ok, input alloc_phys);

    // committed map gives them back
    modport rel_mp (output rel_valid, output rel_phys, output commit_adv);

    // queue owner
    modport list_mp (
        input  alloc_req,
        output alloc_ok,
        output alloc_phys,
        input  rel_valid,
        input  rel_phys,
        input  commit_adv
    );

endinterface

//--- hdl/rename_map.sv
/* speculative map table that renames one instruction per cycle
   looks up the source, takes a destination register from the free list and restores on flush */

`timescale 1ns/1ps
`include "rename_params.svh"

module rename_map (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid_i,
    input  logic                  flush_i,
    output logic                  dispatch_ready_o,
    input  rename_pkg::arch_reg_t dispatch_arch_i,
    input  rename_pkg::arch_reg_t src_arch_i,
    output rename_pkg::phys_reg_t dispatch_phys_o,
    output rename_pkg::phys_reg_t dispatch_old_phys_o,
    output rename_pkg::phys_reg_t src_phys_o,
    input  rename_pkg::phys_reg_t restore_map_i [`RN_ARCH_REGS],
    free_list_if.alloc_mp         fl
);
    import rename_pkg::*;

    // ============================================================
    // speculative table
    // ============================================================

    // newest arch to phys mapping
    phys_reg_t spec_map [`RN_ARCH_REGS];

    // accepted dispatch this cycle
    logic dispatch_fire;

    // ============================================================
    // handshake with the free list
    // ============================================================

    // no allocation while the maps are being restored
    assign fl.alloc_req = dispatch_valid_i && !flush_i;

    // ready follows availability and ignores the request
    assign dispatch_ready_o = fl.alloc_ok && !flush_i;

    assign dispatch_fire = dispatch_valid_i && dispatch_ready_o;

    // ============================================================
    // lookups straight from the table
    // ============================================================

    assign dispatch_phys_o     = fl.alloc_phys;
    // previous owner of the destination is freed when this one commits
    assign dispatch_old_phys_o = spec_map[dispatch_arch_i];
    assign src_phys_o          = spec_map[src_arch_i];

    // ============================================================
    // table update
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity mapping out of reset
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] <= phys_reg_t'(i);
            end
        end else if (flush_i) begin
            // whole table back to committed state
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] <= restore_map_i[i];
            end
        end else if (dispatch_fire) begin
            spec_map[dispatch_arch_i] <= fl.alloc_phys;
        end
    end

endmodule

//--- hdl/rename_params.svh
/* sizing macros for the register-rename core
   included by the package and by every module that needs a table or queue size */

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// ============================================================
// register file sizes
// ============================================================

// architectural registers seen by the ISA
`define RN_ARCH_REGS 32

// physical registers behind the maps
`define RN_PHYS_REGS 64

// free queue depth, physical minus architectural
`define RN_FREE_DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS)

`endif

//--- hdl/rename_pkg.sv
/* shared register-number types for the rename core
   compile first, modules import it inside their bodies */

`include "rename_params.svh"

package rename_pkg;

    // ============================================================
    // register numbers
    // ============================================================

    // index into either map table
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_reg_t;

    // name of a physical register, also the free queue payload
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_reg_t;

    // ============================================================
    // free queue bookkeeping
    // ============================================================

    // head and tail index, wraps naturally at the depth
    typedef logic [$clog2(`RN_FREE_DEPTH)-1:0] free_ptr_t;

    // occupancy, needs one extra bit to hold a full queue
    typedef logic [$clog2(`RN_FREE_DEPTH+1)-1:0] free_cnt_t;

endpackage

//--- hdl/rename_top.sv
/* top level of the rename core with plain ports
   ties the speculative map, committed map and free list together */

`timescale 1ns/1ps
`include "rename_params.svh"

module rename_top (
    input  logic                  clock,
    input  logic                  reset,
    // dispatch, valid/ready
    input  logic                  dispatch_valid_i,
    output logic                  dispatch_ready_o,
    input  rename_pkg::arch_reg_t dispatch_arch_i,
    input  rename_pkg::arch_reg_t src_arch_i,
    output rename_pkg::phys_reg_t dispatch_phys_o,
    output rename_pkg::phys_reg_t dispatch_old_phys_o,
    output rename_pkg::phys_reg_t src_phys_o,
    // retirement, no back-pressure
    input  logic                  commit_valid_i,
    input  rename_pkg::arch_reg_t commit_arch_i,
    input  rename_pkg::phys_reg_t commit_phys_i,
    // recovery
    input  logic                  flush_i,
    output rename_pkg::free_cnt_t free_count_o
);
    import rename_pkg::*;

    // committed table feeding the flush restore
    phys_reg_t committed_map [`RN_ARCH_REGS];

    free_list_if fl_if ();

    // ============================================================
    // blocks
    // ============================================================

    rename_map u_rename_map (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid_i    (dispatch_valid_i),
        .flush_i             (flush_i),
        .dispatch_ready_o    (dispatch_ready_o),
        .dispatch_arch_i     (dispatch_arch_i),
        .src_arch_i          (src_arch_i),
        .dispatch_phys_o     (dispatch_phys_o),
        .dispatch_old_phys_o (dispatch_old_phys_o),
        .src_phys_o          (src_phys_o),
        .restore_map_i       (committed_map),
        .fl                  (fl_if.alloc_mp)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .fl           (fl_if.list_mp),
        .flush_i      (flush_i),
        .free_count_o (free_count_o)
    );

    retire_map u_retire_map (
        .clock           (clock),
        .reset           (reset),
        .commit_valid_i  (commit_valid_i),
        .flush_i         (flush_i),
        .commit_arch_i   (commit_arch_i),
        .commit_phys_i   (commit_phys_i),
        .committed_map_o (committed_map),
        .fl              (fl_if.rel_mp)
    );

endmodule

//--- hdl/retire_map.sv
/* committed map table, one retirement per cycle
   returns the superseded register to the free list and drives the flush restore image */

`timescale 1ns/1ps
`include "rename_params.svh"

module retire_map (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  commit_valid_i,
    input  logic                  flush_i,
    input  rename_pkg::arch_reg_t commit_arch_i,
    input  rename_pkg::phys_reg_t commit_phys_i,
    output rename_pkg::phys_reg_t committed_map_o [`RN_ARCH_REGS],
    free_list_if.rel_mp           fl
);
    import rename_pkg::*;

    // ============================================================
    // committed table
    // ============================================================

    // arch -> phys as of the last retired instruction
    phys_reg_t commit_map [`RN_ARCH_REGS];

    // restore image for the speculative table
    assign committed_map_o = commit_map;

    // ============================================================
    // release toward the free list
    // ============================================================

    // every commit frees the old committed owner
    assign fl.rel_valid  = commit_valid_i;
    assign fl.rel_phys   = commit_map[commit_arch_i];
    assign fl.commit_adv = commit_valid_i;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                commit_map[i] <= phys_reg_t'(i);
            end
        end else if (commit_valid_i) begin
            commit_map[commit_arch_i] <= commit_phys_i;
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // flush and commit are mutually exclusive
    no_flush_on_commit: assert property (@(posedge clock) disable iff (reset)
        !(flush_i && commit_valid_i));

    // renamed destination is always fresh, never its own old mapping
    fresh_dest: assert property (@(posedge clock) disable iff (reset)
        commit_valid_i |-> commit_phys_i != commit_map[commit_arch_i]);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the rename core testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module rename_tb \
    -Mdir obj_dir -o rename_tb_sim -f files.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rename_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

//--- testbench/rename_tb.sv
/* directed testbench for the rename core, checks every cycle against a model of both maps
   and the free queue, then prints a one-line error summary */

`timescale 1ns/1ps
`include "rename_params.svh"

module rename_tb;
    import rename_pkg::*;

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    logic      dispatch_ready;
    arch_reg_t dispatch_arch;
    arch_reg_t src_arch;
    phys_reg_t dispatch_phys;
    phys_reg_t dispatch_old_phys;
    phys_reg_t src_phys;
    logic      commit_valid;
    arch_reg_t commit_arch;
    phys_reg_t commit_phys;
    logic      flush;
    free_cnt_t free_count;

    // ============================================================
    // reference model
    // ============================================================

    phys_reg_t m_spec [`RN_ARCH_REGS];
    phys_reg_t m_comm [`RN_ARCH_REGS];
    phys_reg_t m_queue [`RN_FREE_DEPTH];
    int        m_spec_head;
    int        m_commit_head;
    int        m_tail;
    int        m_count;
    int        m_commit_count;
    // in-flight instructions, oldest first
    arch_reg_t pend_arch [$];
    phys_reg_t pend_phys [$];

    int     n_cycles;
    int     n_errors;
    logic   last_ready;
    integer seed;

    rename_top UUT (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid_i    (dispatch_valid),
        .dispatch_ready_o    (dispatch_ready),
        .dispatch_arch_i     (dispatch_arch),
        .src_arch_i          (src_arch),
        .dispatch_phys_o     (dispatch_phys),
        .dispatch_old_phys_o (dispatch_old_phys),
        .src_phys_o          (src_phys),
        .commit_valid_i      (commit_valid),
        .commit_arch_i       (commit_arch),
        .commit_phys_i       (commit_phys),
        .flush_i             (flush),
        .free_count_o        (free_count)
    );

    always #50 clock = ~clock;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        n_errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    endtask

    task automatic reset_model();
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            m_spec[i] = phys_reg_t'(i);
            m_comm[i] = phys_reg_t'(i);
        end
        // queue holds every register above the architectural ones
        for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
            m_queue[i] = phys_reg_t'(`RN_ARCH_REGS + i);
        end
        m_spec_head    = 0;
        m_commit_head  = 0;
        m_tail         = 0;
        m_count        = `RN_FREE_DEPTH;
        m_commit_count = `RN_FREE_DEPTH;
        pend_arch.delete();
        pend_phys.delete();
    endtask

    // one clock cycle: drive, check mid-cycle, then advance the model
    task automatic run_cycle(input logic dv, input arch_reg_t darch, input arch_reg_t sarch,
                             input logic cv, input logic fl);
        logic      do_commit;
        logic      exp_ready;
        phys_reg_t rel;
        phys_reg_t exp_phys;
        // commits only retire real in-flight work, never beside a flush
        do_commit      = cv && (pend_arch.size() > 0) && !fl;
        dispatch_valid = dv;
        dispatch_arch  = darch;
        src_arch       = sarch;
        commit_valid   = do_commit;
        commit_arch    = do_commit ? pend_arch[0] : '0;
        commit_phys    = do_commit ? pend_phys[0] : '0;
        flush          = fl;
        rel       = m_comm[commit_arch];
        exp_ready = (m_count != 0 || do_commit) && !fl;
        // empty queue passes the released register straight through
        exp_phys  = (m_count == 0) ? rel : m_queue[m_spec_head];
        @(negedge clock);
        n_cycles++;
        last_ready = dispatch_ready;
        if (dispatch_ready !== exp_ready) report_mismatch("dispatch_ready_o",
            32'(dispatch_ready), 32'(exp_ready));
        if (free_count !== free_cnt_t'(m_count)) report_mismatch("free_count_o",
            32'(free_count), 32'(m_count));
        if (src_phys !== m_spec[sarch]) report_mismatch("src_phys_o",
            32'(src_phys), 32'(m_spec[sarch]));
        if (dispatch_old_phys !== m_spec[darch]) report_mismatch("dispatch_old_phys_o",
            32'(dispatch_old_phys), 32'(m_spec[darch]));
        if (exp_ready && dispatch_phys !== exp_phys) report_mismatch("dispatch_phys_o",
            32'(dispatch_phys), 32'(exp_phys));
        // release first, then allocate
        if (do_commit) begin
            m_queue[m_tail]     = rel;
            m_tail              = (m_tail + 1) % `RN_FREE_DEPTH;
            m_commit_head       = (m_commit_head + 1) % `RN_FREE_DEPTH;
            m_comm[commit_arch] = commit_phys;
            m_count++;
            // tail grows by one, committed head moves by one
            m_commit_count = m_commit_count + 1;
            m_commit_count = m_commit_count - 1;
            void'(pend_arch.pop_front());
            void'(pend_phys.pop_front());
        end
        if (dv && exp_ready) begin
            m_spec[darch] = exp_phys;
            m_spec_head   = (m_spec_head + 1) % `RN_FREE_DEPTH;
            m_count--;
            pend_arch.push_back(darch);
            pend_phys.push_back(exp_phys);
        end
        if (fl) begin
            m_spec_head = m_commit_head;
            m_spec      = m_comm;
            m_count     = m_commit_count;
            pend_arch.delete();
            pend_phys.delete();
        end
        @(posedge clock);
        #10;
    endtask

    task automatic dispatch_until_accepted(input arch_reg_t darch, input arch_reg_t sarch);
        int waited;
        waited = 0;
        run_cycle(1'b1, darch, sarch, 1'b0, 1'b0);
        while (!last_ready) begin
            waited++;
            if (waited > 16) begin
                n_errors++;
                $display("timeout: dispatch of arch %0d never accepted", darch);
                break;
            end
            run_cycle(1'b1, darch, sarch, 1'b0, 1'b0);
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic alloc_in_order();
        for (int i = 1; i <= 4; i++) begin
            dispatch_until_accepted(arch_reg_t'(i), arch_reg_t'(i - 1));
        end
        run_cycle(1'b0, '0, arch_reg_t'(4), 1'b0, 1'b0);
    endtask

    task automatic drain_and_stall();
        // 4 already taken, 28 more empties the queue
        for (int i = 0; i < 28; i++) begin
            dispatch_until_accepted(arch_reg_t'(i % 31 + 1), arch_reg_t'(i));
        end
        repeat (3) run_cycle(1'b1, arch_reg_t'(5), arch_reg_t'(5), 1'b0, 1'b0);
        if (free_count !== '0) report_mismatch("free_count_o", 32'(free_count), 32'(0));
    endtask

    task automatic release_in_tail_order();
        repeat (3) run_cycle(1'b0, '0, '0, 1'b1, 1'b0);
        for (int i = 0; i < 3; i++) begin
            dispatch_until_accepted(arch_reg_t'(i + 9), arch_reg_t'(i + 9));
        end
    endtask

    task automatic bypass_when_empty();
        for (int i = 0; i < 2; i++) begin
            run_cycle(1'b1, arch_reg_t'(i + 20), arch_reg_t'(i), 1'b1, 1'b0);
            if (last_ready !== 1'b1) report_mismatch("dispatch_ready_o", 32'(last_ready), 32'(1));
        end
    endtask

    task automatic flush_to_committed();
        repeat (3) run_cycle(1'b0, '0, '0, 1'b1, 1'b0);
        dispatch_until_accepted(arch_reg_t'(3), arch_reg_t'(3));
        dispatch_until_accepted(arch_reg_t'(4), arch_reg_t'(3));
        run_cycle(1'b0, '0, '0, 1'b1, 1'b0);
        // valid held high through the flush, nothing may be taken
        run_cycle(1'b1, arch_reg_t'(3), '0, 1'b0, 1'b1);
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            run_cycle(1'b0, '0, arch_reg_t'(i), 1'b0, 1'b0);
        end
        dispatch_until_accepted(arch_reg_t'(7), arch_reg_t'(7));
    endtask

    task automatic random_traffic();
        logic dv;
        logic cv;
        logic fl;
        repeat (400) begin
            dv = ($random(seed) % 2) != 0;
            cv = ($random(seed) % 3) != 0;
            fl = ($random(seed) % 29) == 0;
            run_cycle(dv, arch_reg_t'($random(seed)), arch_reg_t'($random(seed)), cv, fl);
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_arch  = '0;
        src_arch       = '0;
        commit_valid   = 1'b0;
        commit_arch    = '0;
        commit_phys    = '0;
        flush          = 1'b0;
        n_cycles       = 0;
        n_errors       = 0;
        last_ready     = 1'b0;
        seed           = 74684;
        reset_model();
        repeat (3) @(posedge clock);
        #10;
        reset = 1'b0;

        alloc_in_order();
        drain_and_stall();
        release_in_tail_order();
        bypass_when_empty();
        flush_to_committed();
        random_traffic();

        $display("cycles checked: %0d, errors: %0d", n_cycles, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
